// File: hdl/nes_loader_pkg.sv
// NES cartridge loader shared definitions
// Widths, iNES constants, bus structs and the loader state encoding

package nes_loader_pkg;

	//////////////////////////////////////////////////////////////////////
	// Vector types
	//////////////////////////////////////////////////////////////////////

	typedef logic [7:0]  byte_t;
	typedef logic [21:0] mem_addr_t;     // Cartridge memory space, 4 MB
	typedef logic [21:0] byte_count_t;
	typedef logic [24:0] dl_addr_t;      // Download byte index
	typedef logic [7:0]  filetype_t;

	//////////////////////////////////////////////////////////////////////
	// Bus structs
	//////////////////////////////////////////////////////////////////////

	// One byte strobe from the download port
	typedef struct packed {
		logic     wr;
		dl_addr_t addr;
		byte_t    data;
	} dl_byte_t;

	// One cartridge memory write
	typedef struct packed {
		logic      wr;
		mem_addr_t addr;
		byte_t     data;
	} rom_write_t;

	// Mapper configuration word handed to the console core
	typedef struct packed {
		logic [1:0] pad;
		logic [3:0] prg_ram_shift;  // NES 2.0 only, 64 << n bytes
		logic       has_saves;
		byte_t      submapper_byte; // NES 2.0 only
		logic       four_screen;
		logic       has_chr_ram;
		logic       mirroring;
		logic [2:0] chr_size;       // log2 of 8 KB pages
		logic [2:0] prg_size;       // log2 of 16 KB pages
		byte_t      mapper;
	} mapper_flags_t;

	// Cheat code, each field little endian within itself
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	typedef enum logic [2:0] {
		LOAD_HEADER,
		LOAD_PRG,
		LOAD_CHR,
		LOAD_ERROR,
		LOAD_DONE
	} loader_state_e;

	//////////////////////////////////////////////////////////////////////
	// Constants
	//////////////////////////////////////////////////////////////////////

	localparam int          INES_HEADER_LEN        = 16;
	localparam logic [31:0] INES_MAGIC             = 32'h4E45_531A; // "NES" EOF
	localparam int          PRG_PAGE_SHIFT         = 14;            // 16 KB pages
	localparam int          CHR_PAGE_SHIFT         = 13;            // 8 KB pages
	localparam mem_addr_t   PRG_BASE_ADDR          = 22'h00_0000;
	localparam mem_addr_t   CHR_BASE_ADDR          = 22'h20_0000;
	localparam filetype_t   CHEAT_FILETYPE         = 8'hFF;
	localparam int          CHEAT_RECORD_LEN       = 16;
	localparam logic [7:0]  POST_LOAD_RESET_CYCLES = 8'd255;

endpackage

// File: hdl/ines_header_decoder.sv
// iNES header decoder
// Checks a captured 16-byte header and derives the PRG/CHR sizes
// and the packed mapper flags, NES 2.0 aware

`timescale 1ns/1ns

module ines_header_decoder (
	input  nes_loader_pkg::byte_t         header [0:nes_loader_pkg::INES_HEADER_LEN-1],
	input  logic                          invert_mirroring,
	output logic                          header_ok,
	output nes_loader_pkg::byte_count_t   prg_bytes,
	output nes_loader_pkg::byte_count_t   chr_bytes,
	output nes_loader_pkg::mapper_flags_t flags
);

	logic is_nes20;
	logic is_dirty;
	logic tail_nonzero;

	// Smallest k with pages <= 2^k, saturating at 7
	function automatic logic [2:0] size_code(input nes_loader_pkg::byte_t pages);
		logic [2:0] code;
		code = 3'd7;
		for (int k = 6; k >= 0; k--) begin
			if (pages <= 8'(1 << k))
				code = 3'(k);
		end
		return code;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Header check and image sizes
	//////////////////////////////////////////////////////////////////////

	// Trainers are not supported
	assign header_ok = ({header[0], header[1], header[2], header[3]} ==
		nes_loader_pkg::INES_MAGIC) && !header[6][2];

	assign prg_bytes = nes_loader_pkg::byte_count_t'(header[4]) << nes_loader_pkg::PRG_PAGE_SHIFT;
	assign chr_bytes = nes_loader_pkg::byte_count_t'(header[5]) << nes_loader_pkg::CHR_PAGE_SHIFT;

	//////////////////////////////////////////////////////////////////////
	// Format detection
	//////////////////////////////////////////////////////////////////////

	assign is_nes20 = (header[7][3:2] == 2'b10);

	always_comb begin
		tail_nonzero = 1'b0;
		for (int i = 10; i < nes_loader_pkg::INES_HEADER_LEN; i++) begin
			tail_nonzero = tail_nonzero | (header[i] != 8'h00);
		end
	end

	// Old dumps often carry junk in the reserved bytes
	assign is_dirty = !is_nes20 && ((header[9][7:1] != 7'd0) || tail_nonzero);

	//////////////////////////////////////////////////////////////////////
	// Mapper flags
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		flags                = '0;
		flags.mapper         = {is_dirty ? 4'h0 : header[7][7:4], header[6][7:4]};
		flags.prg_size       = size_code(header[4]);
		flags.chr_size       = size_code(header[5]);
		flags.mirroring      = header[6][0] ^ invert_mirroring;
		flags.has_chr_ram    = (header[5] == 8'h00);  // No CHR ROM pages
		flags.four_screen    = header[6][3];
		flags.has_saves      = header[6][1];          // Battery backed RAM
		flags.submapper_byte = is_nes20 ? header[8] : 8'h00;
		flags.prg_ram_shift  = is_nes20 ? header[10][3:0] : 4'h0;
	end

endmodule

// File: hdl/rom_loader.sv
// iNES ROM loader
// Captures the header, then streams PRG and CHR bytes to the
// cartridge memory write port at their base addresses

`timescale 1ns/1ns

module rom_loader (
	input  logic                          clk,
	input  logic                          reset_nes,
	input  logic                          downloading,
	input  nes_loader_pkg::dl_byte_t      dl,
	input  logic                          invert_mirroring,
	output nes_loader_pkg::rom_write_t    rom_wr,
	output nes_loader_pkg::mapper_flags_t mapper_flags,
	output logic                          busy,
	output logic                          done,
	output logic                          error
);

	localparam logic [3:0] HDR_LAST = 4'(nes_loader_pkg::INES_HEADER_LEN - 1);

	nes_loader_pkg::loader_state_e state;
	nes_loader_pkg::byte_t         header_q [0:nes_loader_pkg::INES_HEADER_LEN-1];
	nes_loader_pkg::byte_t         hdr_view [0:nes_loader_pkg::INES_HEADER_LEN-1];
	nes_loader_pkg::byte_count_t   bytes_left;
	nes_loader_pkg::byte_count_t   chr_left;   // CHR size kept for the second phase
	nes_loader_pkg::mem_addr_t     mem_addr;
	nes_loader_pkg::byte_count_t   dec_prg_bytes;
	nes_loader_pkg::byte_count_t   dec_chr_bytes;
	nes_loader_pkg::mapper_flags_t dec_flags;
	logic [3:0]                    hdr_cnt;
	logic [3:0]                    cap_idx;
	logic                          cap_en;
	logic                          downloading_q;
	logic                          start;
	logic                          dec_ok;

	assign start = downloading && !downloading_q;

	//////////////////////////////////////////////////////////////////////
	// Header capture
	//////////////////////////////////////////////////////////////////////

	// First byte may land on the same cycle as the download start
	assign cap_en  = dl.wr && (start || state == nes_loader_pkg::LOAD_HEADER);
	assign cap_idx = start ? 4'd0 : hdr_cnt;

	always_ff @(posedge clk) begin
		if (cap_en)
			header_q[cap_idx] <= dl.data;
	end

	// Decoder sees the incoming byte so the last one counts immediately
	always_comb begin
		for (int i = 0; i < nes_loader_pkg::INES_HEADER_LEN; i++) begin
			hdr_view[i] = (cap_en && cap_idx == 4'(i)) ? dl.data : header_q[i];
		end
	end

	ines_header_decoder u_decoder (
		.header           (hdr_view),
		.invert_mirroring (invert_mirroring),
		.header_ok        (dec_ok),
		.prg_bytes        (dec_prg_bytes),
		.chr_bytes        (dec_chr_bytes),
		.flags            (dec_flags)
	);

	//////////////////////////////////////////////////////////////////////
	// Loader FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			state         <= nes_loader_pkg::LOAD_HEADER;
			hdr_cnt       <= 4'd0;
			bytes_left    <= '0;
			chr_left      <= '0;
			mem_addr      <= nes_loader_pkg::PRG_BASE_ADDR;
			busy          <= 1'b0;
			done          <= 1'b0;
			error         <= 1'b0;
			rom_wr.wr     <= 1'b0;
			downloading_q <= 1'b0;
		end else begin
			downloading_q <= downloading;
			rom_wr.wr     <= 1'b0;

			if (start) begin
				state   <= nes_loader_pkg::LOAD_HEADER;
				hdr_cnt <= dl.wr ? 4'd1 : 4'd0;
				busy    <= 1'b0;
				done    <= 1'b0;
				error   <= 1'b0;
			end else begin
				case (state)
					nes_loader_pkg::LOAD_HEADER: begin
						if (dl.wr) begin
							hdr_cnt <= hdr_cnt + 4'd1;
							if (hdr_cnt == HDR_LAST) begin
								busy         <= 1'b1;
								mapper_flags <= dec_flags;
								bytes_left   <= dec_prg_bytes;
								chr_left     <= dec_chr_bytes;
								mem_addr     <= nes_loader_pkg::PRG_BASE_ADDR;
								state        <= dec_ok ? nes_loader_pkg::LOAD_PRG
								                       : nes_loader_pkg::LOAD_ERROR;
							end
						end
					end
					nes_loader_pkg::LOAD_PRG, nes_loader_pkg::LOAD_CHR: begin
						if (bytes_left != '0) begin
							if (dl.wr) begin
								rom_wr.wr   <= 1'b1;
								rom_wr.addr <= mem_addr;
								rom_wr.data <= dl.data;
								mem_addr    <= mem_addr + 1'b1;
								bytes_left  <= bytes_left - 1'b1;
							end
						end else if (state == nes_loader_pkg::LOAD_PRG && chr_left != '0) begin
							state      <= nes_loader_pkg::LOAD_CHR;
							mem_addr   <= nes_loader_pkg::CHR_BASE_ADDR;
							bytes_left <= chr_left;
						end else begin
							state <= nes_loader_pkg::LOAD_DONE;  // Image complete
							done  <= 1'b1;
							busy  <= 1'b0;
						end
					end
					nes_loader_pkg::LOAD_ERROR: begin
						done  <= 1'b1;
						error <= 1'b1;
						busy  <= 1'b0;
					end
					default: begin
						// LOAD_DONE waits here for the next download
					end
				endcase
			end
		end
	end

endmodule

// File: hdl/cheat_code_collector.sv
// Cheat code collector
// Gathers one 16-byte cheat record into a code word and
// flags it with a single-cycle valid pulse

`timescale 1ns/1ns

module cheat_code_collector (
	input  logic                        clk,
	input  logic                        reset_nes,
	input  nes_loader_pkg::dl_byte_t    dl,
	output nes_loader_pkg::cheat_code_t cheat_code,
	output logic                        cheat_valid
);

	localparam logic [3:0] LANE_LAST = 4'(nes_loader_pkg::CHEAT_RECORD_LEN - 1);

	nes_loader_pkg::cheat_code_t code_q;
	logic [3:0]                  lane;
	logic [6:0]                  lane_lsb;

	assign lane = dl.addr[3:0];

	// Record layout by lane
	//   0..3   flags     bits 127:96
	//   4..7   address   bits 95:64
	//   8..11  compare   bits 63:32
	//   12..15 replace   bits 31:0
	// Lowest lane of each field is its least significant byte
	assign lane_lsb = {~lane[3:2], lane[1:0], 3'b000};

	always_ff @(posedge clk) begin
		if (dl.wr)
			code_q[lane_lsb +: 8] <= dl.data;
	end

	always_ff @(posedge clk) begin
		if (reset_nes)
			cheat_valid <= 1'b0;
		else
			cheat_valid <= dl.wr && (lane == LANE_LAST);  // Last lane fills the record
	end

	assign cheat_code = code_q;

endmodule

// File: hdl/console_reset_gen.sv
// Console reset generator
// Holds the console in reset until the first ROM download, during
// and shortly after every download, and while the loader reports an error

`timescale 1ns/1ns

module console_reset_gen (
	input  logic clk,
	input  logic reset_nes,
	input  logic downloading,
	input  logic loader_error,
	output logic console_reset
);

	logic       seen_download;
	logic [7:0] post_cnt;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			seen_download <= 1'b0;
			post_cnt      <= 8'd0;
		end else begin
			if (downloading) begin
				seen_download <= 1'b1;
				post_cnt      <= nes_loader_pkg::POST_LOAD_RESET_CYCLES;
			end else if (post_cnt != 8'd0) begin
				post_cnt <= post_cnt - 8'd1;  // Settle time after the load
			end
		end
	end

	assign console_reset = !seen_download
		|| (post_cnt != 8'd0)
		|| downloading
		|| loader_error;

endmodule

// File: hdl/nes_cart_loader_top.sv
// NES cartridge loader top level
// Routes the download stream to the ROM loader or the cheat collector
// by file type and drives the console reset

`timescale 1ns/1ns

module nes_cart_loader_top (
	input  logic                          clk,
	input  logic                          reset_nes,
	input  logic                          downloading,
	input  nes_loader_pkg::filetype_t     filetype,
	input  nes_loader_pkg::dl_byte_t      dl,
	input  logic                          invert_mirroring,
	output nes_loader_pkg::rom_write_t    rom_wr,
	output nes_loader_pkg::mapper_flags_t mapper_flags,
	output logic                          loader_busy,
	output logic                          loader_done,
	output logic                          loader_error,
	output nes_loader_pkg::cheat_code_t   cheat_code,
	output logic                          cheat_valid,
	output logic                          console_reset
);

	nes_loader_pkg::dl_byte_t rom_dl;
	nes_loader_pkg::dl_byte_t cheat_dl;
	logic                     is_cheat;
	logic                     rom_downloading;

	//////////////////////////////////////////////////////////////////////
	// File type routing
	//////////////////////////////////////////////////////////////////////

	assign is_cheat        = (filetype == nes_loader_pkg::CHEAT_FILETYPE);
	assign rom_downloading = downloading && !is_cheat;  // Cheat files leave the console running

	always_comb begin
		rom_dl      = dl;
		rom_dl.wr   = dl.wr && !is_cheat;
		cheat_dl    = dl;
		cheat_dl.wr = dl.wr && is_cheat;
	end

	rom_loader u_rom_loader (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.downloading      (rom_downloading),
		.dl               (rom_dl),
		.invert_mirroring (invert_mirroring),
		.rom_wr           (rom_wr),
		.mapper_flags     (mapper_flags),
		.busy             (loader_busy),
		.done             (loader_done),
		.error            (loader_error)
	);

	cheat_code_collector u_cheat (
		.clk         (clk),
		.reset_nes   (reset_nes),
		.dl          (cheat_dl),
		.cheat_code  (cheat_code),
		.cheat_valid (cheat_valid)
	);

	console_reset_gen u_reset_gen (
		.clk           (clk),
		.reset_nes     (reset_nes),
		.downloading   (rom_downloading),
		.loader_error  (loader_error),
		.console_reset (console_reset)
	);

endmodule

// File: verif/nes_cart_loader_assert.sv
// Cartridge loader protocol checks
// Concurrent assertions bound into the top level

`timescale 1ns/1ns

module nes_cart_loader_assert (
	input logic clk,
	input logic reset_nes,
	input logic cheat_valid,
	input logic loader_busy,
	input logic loader_done,
	input logic loader_error,
	input logic console_reset
);

	// Valid is a single-cycle pulse
	a_cheat_pulse: assert property (@(posedge clk) disable iff (reset_nes)
		cheat_valid |=> !cheat_valid)
		else $error("cheat_valid high on two consecutive cycles");

	a_done_busy: assert property (@(posedge clk) disable iff (reset_nes)
		!(loader_done && loader_busy))
		else $error("loader_done and loader_busy both high");

	a_error_reset: assert property (@(posedge clk) disable iff (reset_nes)
		loader_error |-> console_reset)
		else $error("loader_error without console_reset");  // Console must not run a bad image

endmodule

bind nes_cart_loader_top nes_cart_loader_assert u_assert (
	.clk           (clk),
	.reset_nes     (reset_nes),
	.cheat_valid   (cheat_valid),
	.loader_busy   (loader_busy),
	.loader_done   (loader_done),
	.loader_error  (loader_error),
	.console_reset (console_reset)
);

// File: verif/tb_nes_cart_loader.sv
// Testbench for the NES cartridge loader
// Streams iNES images, bad headers and a cheat record through the top level
// and checks writes, mapper flags, cheat codes and the console reset

`timescale 1ns/1ns

module tb_nes_cart_loader;

	typedef nes_loader_pkg::byte_t bytes16_t [0:15];

	localparam int TIMEOUT_CYCLES = 200000;  // Longest run is about 90k cycles
	localparam nes_loader_pkg::filetype_t ROM_FILETYPE = 8'h01;

	logic                          clk = 1'b0;
	logic                          reset_nes;
	logic                          downloading;
	nes_loader_pkg::filetype_t     filetype;
	nes_loader_pkg::dl_byte_t      dl;
	logic                          invert_mirroring;
	nes_loader_pkg::rom_write_t    rom_wr;
	nes_loader_pkg::mapper_flags_t mapper_flags;
	logic                          loader_busy;
	logic                          loader_done;
	logic                          loader_error;
	nes_loader_pkg::cheat_code_t   cheat_code;
	logic                          cheat_valid;
	logic                          console_reset;

	nes_loader_pkg::rom_write_t    exp_writes [$];  // Writes still to come, in order
	nes_loader_pkg::cheat_code_t   exp_cheat;
	int                            cheat_pulses = 0;
	int                            cycle_count = 0;

	always #2 clk = ~clk;

	nes_cart_loader_top dut (.*);

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	// Smallest k with pages <= 2^k, 7 when above 64 pages
	function automatic logic [2:0] size_log2(input nes_loader_pkg::byte_t pages);
		int k;
		k = 0;
		while (k < 7 && (1 << k) < int'(pages))
			k++;
		return 3'(k);
	endfunction

	function automatic nes_loader_pkg::mapper_flags_t ref_flags(input bytes16_t h,
		input logic inv);
		nes_loader_pkg::mapper_flags_t f;
		logic                          nes2;
		logic                          dirty;
		nes2  = h[7][3] && !h[7][2];
		dirty = (h[9][7:1] != 7'd0);
		for (int i = 10; i < 16; i++) begin
			if (h[i] != 8'h00)
				dirty = 1'b1;
		end
		dirty = dirty && !nes2;
		f = '0;
		f.mapper[3:0] = h[6][7:4];
		f.mapper[7:4] = dirty ? 4'h0 : h[7][7:4];
		f.prg_size    = size_log2(h[4]);
		f.chr_size    = size_log2(h[5]);
		f.mirroring   = h[6][0] ^ inv;
		f.has_chr_ram = (h[5] == 8'h00);
		f.four_screen = h[6][3];
		f.has_saves   = h[6][1];
		if (nes2) begin
			f.submapper_byte = h[8];
			f.prg_ram_shift  = h[10][3:0];
		end
		return f;
	endfunction

	// Lane k goes to field k/4, byte k%4 of that field
	function automatic nes_loader_pkg::cheat_code_t ref_cheat(input bytes16_t b);
		nes_loader_pkg::cheat_code_t c;
		c = '0;
		for (int k = 0; k < 16; k++) begin
			case (k / 4)
				0:       c.flags[8*(k%4) +: 8]   = b[k];
				1:       c.address[8*(k%4) +: 8] = b[k];
				2:       c.compare[8*(k%4) +: 8] = b[k];
				default: c.replace[8*(k%4) +: 8] = b[k];
			endcase
		end
		return c;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1, "Simulation stopped at first error");
	endtask

	task automatic check_rom_write(input nes_loader_pkg::rom_write_t got,
		input nes_loader_pkg::rom_write_t exp, input string what);
		if (got !== exp)
			report_error($sformatf("ERR %0t ns: %s got addr %h data %h, expected addr %h data %h",
				$time, what, got.addr, got.data, exp.addr, exp.data));
	endtask

	task automatic check_flags(input nes_loader_pkg::mapper_flags_t got,
		input nes_loader_pkg::mapper_flags_t exp, input string what);
		if (got !== exp)
			report_error($sformatf("ERR %0t ns: %s got %h expected %h", $time, what, got, exp));
	endtask

	task automatic check_cheat(input nes_loader_pkg::cheat_code_t got,
		input nes_loader_pkg::cheat_code_t exp, input string what);
		if (got !== exp)
			report_error($sformatf("ERR %0t ns: %s got %h expected %h", $time, what, got, exp));
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
			report_error($sformatf("ERR %0t ns: %s got %b expected %b", $time, what, got, exp));
	endtask

	// Outputs settle after the rising edge, so look at them on the falling one
	always @(negedge clk) begin : result_monitor
		nes_loader_pkg::rom_write_t exp;
		if (!reset_nes && rom_wr.wr === 1'b1) begin
			if (exp_writes.size() == 0) begin
				report_error($sformatf("Unexpected ROM write to address %h at %0t ns",
					rom_wr.addr, $time));
			end else begin
				exp = exp_writes.pop_front();
				check_rom_write(rom_wr, exp, "rom_wr");
			end
		end
		if (!reset_nes && cheat_valid === 1'b1) begin
			cheat_pulses++;
			check_cheat(cheat_code, exp_cheat, "cheat_code");
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the tests did not finish", cycle_count);
			$display("STATUS: FAIL");
			$fatal(1, "Timeout");
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	task automatic send_byte(input nes_loader_pkg::dl_addr_t addr,
		input nes_loader_pkg::byte_t data);
		nes_loader_pkg::dl_byte_t s;
		s.wr   = 1'b1;
		s.addr = addr;
		s.data = data;
		@(posedge clk);
		dl <= s;
		@(posedge clk);
		dl.wr <= 1'b0;  // One idle cycle between strobes
	endtask

	task automatic start_download(input nes_loader_pkg::filetype_t ft);
		@(posedge clk);
		filetype    <= ft;
		downloading <= 1'b1;
	endtask

	task automatic end_download();
		@(posedge clk);
		downloading <= 1'b0;
	endtask

	task automatic build_header(output bytes16_t h, input nes_loader_pkg::byte_t prg,
		input nes_loader_pkg::byte_t chr, input nes_loader_pkg::byte_t f6,
		input nes_loader_pkg::byte_t f7);
		for (int i = 0; i < 16; i++)
			h[i] = 8'h00;
		h[0] = nes_loader_pkg::INES_MAGIC[31:24];
		h[1] = nes_loader_pkg::INES_MAGIC[23:16];
		h[2] = nes_loader_pkg::INES_MAGIC[15:8];
		h[3] = nes_loader_pkg::INES_MAGIC[7:0];
		h[4] = prg;
		h[5] = chr;
		h[6] = f6;
		h[7] = f7;
	endtask

	// Random payload, each byte queued as the write it must produce
	task automatic send_body(input int count, input nes_loader_pkg::mem_addr_t base,
		input nes_loader_pkg::dl_addr_t first);
		nes_loader_pkg::rom_write_t w;
		nes_loader_pkg::byte_t      d;
		for (int i = 0; i < count; i++) begin
			d      = nes_loader_pkg::byte_t'($urandom);
			w.wr   = 1'b1;
			w.addr = base + nes_loader_pkg::mem_addr_t'(i);
			w.data = d;
			exp_writes.push_back(w);
			send_byte(first + nes_loader_pkg::dl_addr_t'(i), d);
		end
	endtask

	task automatic load_image(input bytes16_t h, input logic stream_body);
		int prg_len;
		int chr_len;
		prg_len = int'(h[4]) << nes_loader_pkg::PRG_PAGE_SHIFT;
		chr_len = int'(h[5]) << nes_loader_pkg::CHR_PAGE_SHIFT;
		start_download(ROM_FILETYPE);
		for (int i = 0; i < 16; i++)
			send_byte(nes_loader_pkg::dl_addr_t'(i), h[i]);
		// Busy is due one cycle after the last header byte
		@(negedge clk);
		check_bit(loader_busy, 1'b1, "loader_busy after header");
		check_bit(loader_done, 1'b0, "loader_done after header");
		check_bit(loader_error, 1'b0, "loader_error after header");
		check_bit(console_reset, 1'b1, "console_reset during download");
		check_flags(mapper_flags, ref_flags(h, invert_mirroring), "mapper_flags");
		if (stream_body) begin
			send_body(prg_len, nes_loader_pkg::PRG_BASE_ADDR, 25'd16);
			send_body(chr_len, nes_loader_pkg::CHR_BASE_ADDR,
				nes_loader_pkg::dl_addr_t'(16 + prg_len));
			@(negedge clk);
			while (!loader_done)
				@(negedge clk);
			check_bit(loader_error, 1'b0, "loader_error after image");
			check_bit(loader_busy, 1'b0, "loader_busy after image");
			@(negedge clk);
			if (exp_writes.size() != 0)
				report_error($sformatf("%0d expected ROM writes never appeared", exp_writes.size()));
		end
	endtask

	task automatic load_bad_header(input bytes16_t h);
		start_download(ROM_FILETYPE);
		for (int i = 0; i < 16; i++)
			send_byte(nes_loader_pkg::dl_addr_t'(i), h[i]);
		for (int i = 16; i < 24; i++)
			send_byte(nes_loader_pkg::dl_addr_t'(i), nes_loader_pkg::byte_t'($urandom));
		@(negedge clk);
		while (!loader_done)
			@(negedge clk);
		check_bit(loader_error, 1'b1, "loader_error on bad header");
		check_bit(console_reset, 1'b1, "console_reset on loader error");
		end_download();
		repeat (300) @(negedge clk);  // Past the post-load hold
		check_bit(console_reset, 1'b1, "console_reset held by loader error");
	endtask

	initial begin
		bytes16_t hdr;
		bytes16_t rec;
		void'($urandom(32'h9977));
		reset_nes        = 1'b1;
		downloading      = 1'b0;
		filetype         = '0;
		dl               = '0;
		invert_mirroring = 1'b0;
		repeat (5) @(posedge clk);
		reset_nes <= 1'b0;
		@(negedge clk);
		check_bit(rom_wr.wr, 1'b0, "rom_wr.wr after reset");
		check_bit(loader_busy, 1'b0, "loader_busy after reset");
		check_bit(loader_done, 1'b0, "loader_done after reset");
		check_bit(loader_error, 1'b0, "loader_error after reset");
		check_bit(cheat_valid, 1'b0, "cheat_valid after reset");
		check_bit(console_reset, 1'b1, "console_reset before first download");

		// One PRG and one CHR page, then the post-load reset hold
		build_header(hdr, 8'd1, 8'd1, 8'h11, 8'h00);
		load_image(hdr, 1'b1);
		end_download();
		repeat (nes_loader_pkg::POST_LOAD_RESET_CYCLES) begin
			@(negedge clk);
			check_bit(console_reset, 1'b1, "console_reset in post-load hold");
		end
		@(negedge clk);
		check_bit(console_reset, 1'b0, "console_reset after post-load hold");

		// iNES 1.0 with inverted mirroring
		@(posedge clk);
		invert_mirroring <= 1'b1;
		build_header(hdr, 8'd2, 8'd4, 8'h43, 8'h10);
		load_image(hdr, 1'b0);
		end_download();
		@(posedge clk);
		invert_mirroring <= 1'b0;

		// NES 2.0
		build_header(hdr, 8'd3, 8'd1, 8'h28, 8'h58);
		hdr[8]  = 8'h21;
		hdr[10] = 8'h07;
		hdr[12] = 8'h01;
		load_image(hdr, 1'b0);
		end_download();

		// Dirty header, no CHR pages
		build_header(hdr, 8'd1, 8'd0, 8'h30, 8'h40);
		hdr[12] = 8'h55;
		load_image(hdr, 1'b1);
		end_download();

		// Wrong magic, then trainer present
		build_header(hdr, 8'd1, 8'd1, 8'h00, 8'h00);
		hdr[3] = 8'h1B;
		load_bad_header(hdr);
		build_header(hdr, 8'd1, 8'd1, 8'h04, 8'h00);
		load_bad_header(hdr);

		// Cheat record at download offset 32, lanes from the low index bits
		for (int k = 0; k < 16; k++)
			rec[k] = nes_loader_pkg::byte_t'($urandom);
		exp_cheat    = ref_cheat(rec);
		cheat_pulses = 0;
		start_download(nes_loader_pkg::CHEAT_FILETYPE);
		for (int k = 0; k < 16; k++)
			send_byte(nes_loader_pkg::dl_addr_t'(32 + k), rec[k]);
		@(negedge clk);
		while (cheat_pulses == 0)
			@(negedge clk);
		repeat (8) @(negedge clk);
		check_bit(cheat_pulses == 1, 1'b1, "single cheat_valid pulse");
		end_download();

		repeat (4) @(negedge clk);
		$display("STATUS: PASS");
		$finish;
	end

endmodule

// File: files.f
hdl/nes_loader_pkg.sv
hdl/ines_header_decoder.sv
hdl/rom_loader.sv
hdl/cheat_code_collector.sv
hdl/console_reset_gen.sv
hdl/nes_cart_loader_top.sv
verif/nes_cart_loader_assert.sv
verif/tb_nes_cart_loader.sv

// File: run.sh
#!/bin/sh
# Build and run the cartridge loader testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_nes_cart_loader -f files.f
./obj_dir/Vtb_nes_cart_loader | tee sim.log

if grep -q "STATUS: PASS" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
